// File: flist.f
+incdir+rtl
rtl/periph_pkg.sv
rtl/periph_decode.sv
rtl/gpio_ctrl.sv
rtl/pwm_byte_periph.sv
rtl/pin_out_mux.sv
rtl/read_return.sv
rtl/periph_top.sv
tb/tb_periph_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the peripheral block testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_periph_top
./obj_dir/Vtb_periph_top 2>&1 | tee sim.log
if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

// File: tb/tb_periph_top.sv
/*
 * Testbench for the peripheral block
 * Drives core reads and writes against periph_top and checks reset
 * state, GPIO, pin routing, PWM duty, audio select and bus timing.
 */
`default_nettype none
`timescale 1ns/1ns

module tb_periph_top;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 2000;
    localparam int READY_LIMIT = 16;    // Cycles a read may wait for ready

    logic        clk, rst_n, i_data_read_complete;
    logic [7:0]  i_ui_in;
    logic [10:0] i_addr;
    logic [31:0] i_data;
    logic [1:0]  i_data_write_n, i_data_read_n;
    wire  [7:0]  o_uo_out;
    wire         o_audio, o_audio_select, o_data_ready;
    wire  [31:0] o_data;

    int mismatches = 0;
    int failures   = 0;

    periph_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Write ready comes in the write cycle itself
    write_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (i_data_write_n != 2'b11) |-> o_data_ready)
        else begin
            mismatches++;
            $display("MISMATCH time=%0t o_data_ready expected=1 actual=%b", $time, o_data_ready);
        end

    read_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_data_read_n != 2'b11) |=> o_data_ready)
        else begin
            mismatches++;
            $display("MISMATCH time=%0t o_data_ready expected=1 actual=%b", $time, o_data_ready);
        end

    task automatic next_drive();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected)
            else begin
                mismatches++;
                $display("MISMATCH time=%0t %s expected=%h actual=%h",
                         $time, name, expected, actual);
            end
    endtask

    task automatic bus_write(input logic [10:0] addr, input logic [31:0] data);
        i_addr         = addr;
        i_data         = data;
        i_data_write_n = 2'b10;             // Word write
        @(negedge clk);
        check_value("o_data_ready", {31'h0, o_data_ready}, 32'h1);
        next_drive();
        i_data_write_n = 2'b11;
    endtask

    // Holds read until ready, optionally longer, then pulses read-complete
    task automatic bus_read(input logic [10:0] addr, input int hold_cycles,
                            output logic [31:0] data);
        int          cycles;
        logic [31:0] rnd;
        cycles        = 0;
        i_addr        = addr;
        i_data_read_n = 2'b10;
        @(negedge clk);
        while (o_data_ready !== 1'b1 && cycles < READY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (o_data_ready !== 1'b1) begin
            failures++;
            $display("Read of address %h got no data ready within %0d cycles", addr, cycles);
        end
        check_value("read latency", cycles, 32'd1);
        data = o_data;
        for (int i = 0; i < hold_cycles; i++) begin
            next_drive();
            rnd     = $urandom;
            i_ui_in = rnd[7:0];             // Input moves, returned word must not
            @(negedge clk);
            check_value("o_data", o_data, data);
        end
        next_drive();
        i_data_read_n        = 2'b11;
        i_data_read_complete = 1'b1;
        next_drive();
        i_data_read_complete = 1'b0;
    endtask

    task automatic read_check(input logic [10:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        bus_read(addr, 0, data);
        check_value($sformatf("o_data at %h", addr), data, expected);
    endtask

    initial begin
        logic [31:0] rnd, rdata;
        logic [10:0] faddr;
        logic [7:0]  gpio_val, duty, exp_pins;
        int          highs;
        void'($urandom(91473));
        rst_n                = 1'b0;
        i_ui_in              = 8'h00;
        i_addr               = 11'h000;
        i_data               = 32'h0;
        i_data_write_n       = 2'b11;
        i_data_read_n        = 2'b11;
        i_data_read_complete = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Reset state, pins 0/1 on slot 2 and the rest on GPIO
        @(negedge clk);
        check_value("o_uo_out", {24'h0, o_uo_out}, 32'h0);
        check_value("o_audio_select", {31'h0, o_audio_select}, 32'h0);
        next_drive();
        read_check(11'h060, 32'd2);
        read_check(11'h064, 32'd2);
        for (faddr = 11'h068; faddr <= 11'h07C; faddr = faddr + 11'd4) read_check(faddr, 32'd1);

        // GPIO output and input readback
        for (faddr = 11'h060; faddr <= 11'h07C; faddr = faddr + 11'd4) bus_write(faddr, 32'h1);
        rnd      = $urandom;
        gpio_val = rnd[7:0];
        bus_write(11'h040, rnd);            // Only the low byte lands
        @(negedge clk);
        check_value("o_uo_out", {24'h0, o_uo_out}, {24'h0, gpio_val});
        next_drive();
        read_check(11'h040, {24'h0, gpio_val});
        rnd     = $urandom;
        i_ui_in = rnd[7:0];
        read_check(11'h044, {24'h0, rnd[7:0]});

        // Pin 2 on PWM, pins 3 and 4 on empty slots
        bus_write(11'h450, 32'h80);
        bus_write(11'h068, 32'h15);
        bus_write(11'h06C, 32'h03);
        bus_write(11'h070, 32'h12);
        repeat (300) begin
            @(negedge clk);
            exp_pins = (gpio_val & 8'hE3) | {5'h0, o_audio, 2'b00};
            check_value("o_uo_out", {24'h0, o_uo_out}, {24'h0, exp_pins});
        end
        next_drive();

        // PWM duty over one full counter period
        rnd  = $urandom;
        duty = rnd[7:0];
        bus_write(11'h450, {24'h0, duty});
        highs = 0;
        repeat (256) begin
            @(negedge clk);
            if (o_audio) highs++;
        end
        check_value("o_audio high count", highs, {24'h0, duty});
        next_drive();
        read_check(11'h450, {24'h0, duty});
        read_check(11'h451, 32'h0);

        // Audio select is bit 2 of a 3-bit register
        repeat (4) begin
            rnd = $urandom;
            bus_write(11'h050, rnd);
            @(negedge clk);
            check_value("o_audio_select", {31'h0, o_audio_select}, {31'h0, rnd[2]});
            next_drive();
            read_check(11'h050, {29'h0, rnd[2:0]});
        end

        // Read data held across a long read while the input changes
        rnd     = $urandom;
        i_ui_in = rnd[7:0];
        bus_read(11'h044, 5, rdata);
        check_value("o_data", rdata, {24'h0, rnd[7:0]});

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within the watchdog limit");
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/periph_top.sv
/*
 * Peripheral block top level
 * Packs the core's address, data and strobes into the bus struct,
 * then wires decoder, GPIO, PWM, pin mux and read return together.
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_params.svh"

module periph_top import periph_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [7:0]               i_ui_in,
    output logic [7:0]              o_uo_out,
    output logic                    o_audio,
    output logic                    o_audio_select,
    input  wire [`PERI_ADDR_W-1:0]  i_addr,
    input  wire [`PERI_DATA_W-1:0]  i_data,
    input  wire [1:0]               i_data_write_n,
    input  wire [1:0]               i_data_read_n,
    output logic [`PERI_DATA_W-1:0] o_data,
    output logic                    o_data_ready,
    input  wire                     i_data_read_complete
);

    access_size_e wr_size;
    access_size_e rd_size;
    periph_bus_t  bus;

    logic                    gpio_wr, pwm_wr;
    logic [5:0]              offset;
    logic [`PERI_DATA_W-1:0] gpio_rdata, rdata;
    logic [7:0]              pwm_rdata, gpio_out, pwm_out;
    pin_func_t [`PERI_NUM_PINS-1:0] pin_func;

    assign wr_size = access_size_e'(i_data_write_n);
    assign rd_size = access_size_e'(i_data_read_n);
    // Size is only used as active or idle
    assign bus = '{addr: i_addr, wdata: i_data,
                   wr: (wr_size != SIZE_NONE), rd: (rd_size != SIZE_NONE)};

    periph_decode u_decode (
        .i_bus(bus), .i_gpio_rdata(gpio_rdata), .i_pwm_rdata(pwm_rdata),
        .o_gpio_wr(gpio_wr), .o_pwm_wr(pwm_wr), .o_offset(offset), .o_rdata(rdata)
    );

    gpio_ctrl u_gpio (
        .clk(clk), .rst_n(rst_n), .i_wr(gpio_wr), .i_offset(offset),
        .i_wdata(bus.wdata[7:0]), .i_ui_in(i_ui_in), .o_rdata(gpio_rdata),
        .o_gpio_out(gpio_out), .o_pin_func(pin_func), .o_audio_select(o_audio_select)
    );

    pwm_byte_periph u_pwm (
        .clk(clk), .rst_n(rst_n), .i_wr(pwm_wr), .i_offset(offset[3:0]),
        .i_wdata(bus.wdata[7:0]), .o_rdata(pwm_rdata), .o_pwm(pwm_out)
    );

    pin_out_mux u_pin_mux (
        .i_pin_func(pin_func), .i_gpio_out(gpio_out), .i_pwm_out(pwm_out),
        .o_uo_out(o_uo_out)
    );

    read_return u_read_return (
        .clk(clk), .rst_n(rst_n), .i_bus(bus), .i_rdata(rdata),
        .i_read_complete(i_data_read_complete), .o_data(o_data),
        .o_data_ready(o_data_ready)
    );

    assign o_audio = pwm_out[7];   // PWM level on the audio pin

endmodule

`default_nettype wire

// File: rtl/read_return.sv
/*
 * Read return register
 * Captures the addressed read data on the first read cycle and holds
 * it until the core signals completion. Ready follows read one cycle
 * later and is immediate for writes.
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_params.svh"

module read_return import periph_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,
    input  periph_bus_t             i_bus,
    input  wire [`PERI_DATA_W-1:0]  i_rdata,
    input  wire                     i_read_complete,
    output logic [`PERI_DATA_W-1:0] o_data,
    output logic                    o_data_ready
);

    logic [`PERI_DATA_W-1:0] data_q;
    logic                    hold_q;
    logic                    ready_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) hold_q <= 1'b0;
            if (i_bus.rd && !hold_q) hold_q <= 1'b1;
            ready_q <= i_bus.rd;
        end
    end

    // First read cycle only, later cycles leave the value alone
    always_ff @(posedge clk) begin
        if (i_bus.rd && !hold_q) data_q <= i_rdata;
    end

    assign o_data       = data_q;
    assign o_data_ready = ready_q || i_bus.wr;

    // Completion only ever follows a captured read
    a_complete_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        i_read_complete |-> hold_q)
        else $error("read_return: read-complete without a held read");

endmodule

`default_nettype wire

// File: rtl/pin_out_mux.sv
/*
 * Output pin multiplexer
 * Each pin takes its own bit from the slot named by its function
 * select. Only GPIO and the PWM slot drive anything.
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_params.svh"

module pin_out_mux import periph_pkg::*; (
    input  pin_func_t [`PERI_NUM_PINS-1:0] i_pin_func,
    input  wire  [7:0]                     i_gpio_out,
    input  wire  [7:0]                     i_pwm_out,
    output logic [7:0]                     o_uo_out
);

    always_comb begin
        for (int i = 0; i < `PERI_NUM_PINS; i++) begin
            o_uo_out[i] = 1'b0;   // Empty slots drive low
            if (i_pin_func[i].simple) begin
                if (i_pin_func[i].slot == `PERI_SLOT_PWM)
                    o_uo_out[i] = i_pwm_out[i];
            end else if (i_pin_func[i].slot == `PERI_SLOT_GPIO) begin
                o_uo_out[i] = i_gpio_out[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pwm_byte_periph.sv
/*
 * 8-bit PWM byte peripheral (byte slot 5)
 * Free-running counter compared against a duty register, so each
 * 256-cycle period holds exactly duty high cycles. All output bits
 * carry the same level.
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_params.svh"

module pwm_byte_periph (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        i_wr,
    input  wire  [3:0] i_offset,
    input  wire  [7:0] i_wdata,
    output logic [7:0] o_rdata,
    output logic [7:0] o_pwm
);

    logic [7:0] cnt_q;
    logic [7:0] duty_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            duty_q <= '0;
        end else begin
            cnt_q <= cnt_q + 8'd1;   // Wraps every 256 cycles
            if (i_wr && i_offset == `PWM_DUTY_OFS) begin
                duty_q <= i_wdata;
            end
        end
    end

    // Duty 0 never high, no full-on setting
    assign o_pwm = {8{cnt_q < duty_q}};

    always_comb begin
        if (i_offset == `PWM_DUTY_OFS)
            o_rdata = duty_q;
        else
            o_rdata = '0;
    end

endmodule

`default_nettype wire

// File: rtl/gpio_ctrl.sv
/*
 * GPIO register block (full slot 1)
 * Output byte, input readback, eight per-pin function selects and
 * the audio-select register. Writes land on the clock edge, reads
 * are combinational on the offset.
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_params.svh"

module gpio_ctrl import periph_pkg::*; (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         i_wr,
    input  wire  [5:0]                  i_offset,
    input  wire  [7:0]                  i_wdata,
    input  wire  [7:0]                  i_ui_in,
    output logic [`PERI_DATA_W-1:0]     o_rdata,
    output logic [7:0]                  o_gpio_out,
    output pin_func_t [`PERI_NUM_PINS-1:0] o_pin_func,
    output logic                        o_audio_select
);

    logic [7:0]                      out_q;
    logic [2:0]                      audio_q;
    pin_func_t [`PERI_NUM_PINS-1:0]  func_q;

    logic       func_hit;
    logic [2:0] func_idx;

    // Function selects sit at 0x20 + 4*pin
    assign func_hit = (i_offset & 6'h23) == `GPIO_FUNC_OFS;
    assign func_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q   <= '0;
            audio_q <= '0;
            for (int i = 0; i < `PERI_NUM_PINS; i++) begin
                func_q[i].simple <= 1'b0;
                func_q[i].slot   <= (i < 2) ? `PERI_SLOT_UART : `PERI_SLOT_GPIO;
            end
        end else if (i_wr) begin
            if (i_offset == `GPIO_OUT_OFS)   out_q   <= i_wdata;
            if (i_offset == `GPIO_AUDIO_OFS) audio_q <= i_wdata[2:0];
            if (func_hit) func_q[func_idx] <= pin_func_t'(i_wdata[4:0]);
        end
    end

    always_comb begin
        if (i_offset == `GPIO_OUT_OFS)
            o_rdata = {24'h0, out_q};
        else if (i_offset == `GPIO_IN_OFS)
            o_rdata = {24'h0, i_ui_in};      // Live pins, not latched
        else if (i_offset == `GPIO_AUDIO_OFS)
            o_rdata = {29'h0, audio_q};
        else if (func_hit)
            o_rdata = {27'h0, func_q[func_idx]};
        else
            o_rdata = '0;
    end

    assign o_gpio_out     = out_q;
    assign o_pin_func     = func_q;
    assign o_audio_select = audio_q[2];

    // Pin routing only moves under a bus write
    a_func_wr_only: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(func_q) |-> $past(i_wr))
        else $error("gpio: function select changed without a write");

endmodule

`default_nettype wire

// File: rtl/periph_decode.sv
/*
 * Peripheral address decoder
 * Splits the address into full or byte slot, slot number and offset,
 * raises the write strobe of the populated target and returns its
 * read data. Empty slots read as zero.
 */
`default_nettype none
`timescale 1ns/1ns

`include "periph_params.svh"

module periph_decode import periph_pkg::*; (
    input  periph_bus_t             i_bus,
    input  wire [`PERI_DATA_W-1:0]  i_gpio_rdata,
    input  wire [7:0]               i_pwm_rdata,
    output logic                    o_gpio_wr,
    output logic                    o_pwm_wr,
    output logic [5:0]              o_offset,
    output logic [`PERI_DATA_W-1:0] o_rdata
);

    periph_sel_t sel;

    always_comb begin
        sel.simple = i_bus.addr[`PERI_SIMPLE_BIT];
        if (sel.simple) begin
            sel.slot   = i_bus.addr[7:4];           // 16-byte slots
            sel.offset = {2'b00, i_bus.addr[3:0]};
        end else begin
            sel.slot   = i_bus.addr[9:6];           // 64-byte slots
            sel.offset = i_bus.addr[5:0];
        end
    end

    assign o_gpio_wr = i_bus.wr && !sel.simple && (sel.slot == `PERI_SLOT_GPIO);
    assign o_pwm_wr  = i_bus.wr && sel.simple && (sel.slot == `PERI_SLOT_PWM);
    assign o_offset  = sel.offset;

    // Read data of the addressed slot, byte slots zero-extended
    always_comb begin
        o_rdata = '0;
        if (sel.simple) begin
            if (sel.slot == `PERI_SLOT_PWM) o_rdata = {24'h0, i_pwm_rdata};
        end else if (sel.slot == `PERI_SLOT_GPIO) begin
            o_rdata = i_gpio_rdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/periph_pkg.sv
/*
 * Peripheral block types
 * Core access-size code, the packed bus request, the decoded
 * target and the per-pin output source.
 */
`default_nettype none

`include "periph_params.svh"

package periph_pkg;

    // Core size code, 11 means idle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_e;

    // One request from the core, as seen by every stage
    typedef struct packed {
        logic [`PERI_ADDR_W-1:0] addr;
        logic [`PERI_DATA_W-1:0] wdata;
        logic                    wr;    // Write active
        logic                    rd;    // Read active
    } periph_bus_t;

    typedef struct packed {
        logic       simple;   // Byte slot when set
        logic [3:0] slot;
        logic [5:0] offset;
    } periph_sel_t;

    // Pin source, same layout as the function-select register
    typedef struct packed {
        logic       simple;
        logic [3:0] slot;
    } pin_func_t;

endpackage

`default_nettype wire

// File: rtl/periph_params.svh
/*
 * Peripheral block parameters
 * Bus widths, slot numbers and register offsets shared by the
 * address decoder, the GPIO block and the PWM byte peripheral.
 */
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

`define PERI_ADDR_W      11
`define PERI_DATA_W      32
`define PERI_NUM_PINS    8
`define PERI_SIMPLE_BIT  10      // High half of the map holds the byte slots

`define PERI_SLOT_GPIO   4'd1
`define PERI_SLOT_UART   4'd2    // Unpopulated, still the reset source for pins 0/1
`define PERI_SLOT_PWM    4'd5

`define GPIO_OUT_OFS     6'h00
`define GPIO_IN_OFS      6'h04
`define GPIO_AUDIO_OFS   6'h10
`define GPIO_FUNC_OFS    6'h20   // One word per pin from here

`define PWM_DUTY_OFS     4'h0

`endif
